/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = npc_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); false)
	cat $(LOG)
	! grep -qF "** FAIL **" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu import npc_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_t     op,
    output logic [31:0] y
);

    // shift amount from the low five bits only
    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_XOR:  y = a ^ b;
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            ALU_SLL:  y = a << shamt;
            ALU_SRL:  y = a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  y = $signed(a) >>> shamt;
            // compares return 1 or 0
            ALU_SLTU: y = {31'd0, a < b};
            ALU_EQ:   y = {31'd0, a == b};
            ALU_NE:   y = {31'd0, a != b};
            ALU_LT:   y = {31'd0, $signed(a) < $signed(b)};
            default:  y = '0;
        endcase
    end

endmodule

/* hdl/inst_decoder.sv */
`timescale 1ns/1ps
`include "npc_consts.svh"

module inst_decoder import npc_pkg::*; (
    input  logic [31:0] inst,
    output decode_t     dec
);

    // major opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // all immediates sign extended from bit 31
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // default is a no-op: no reg write, no memory access
        dec        = '0;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.alu_op = ALU_ADD;
        dec.wb_sel = WB_ALU;
        case (opcode)
            OP_LUI: begin
                dec.imm     = imm_u;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = WB_IMM;
            end
            OP_AUIPC: begin
                // pc + imm through the alu
                dec.imm         = imm_u;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen     = 1'b1;
            end
            OP_JAL: begin
                dec.imm     = imm_j;
                dec.is_jal  = 1'b1;
                dec.reg_wen = 1'b1;
                dec.wb_sel  = WB_PC4;
            end
            OP_JALR: begin
                // target rs1 + imm comes out of the alu
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                if (funct3 == 3'b000) begin
                    dec.is_jalr = 1'b1;
                    dec.reg_wen = 1'b1;
                    dec.wb_sel  = WB_PC4;
                end
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = ALU_EQ;
                    3'b001: dec.alu_op = ALU_NE;
                    // bge: taken when not less-than
                    3'b101: begin
                        dec.alu_op         = ALU_LT;
                        dec.branch_on_zero = 1'b1;
                    end
                    3'b110: dec.alu_op = ALU_SLTU;
                    // bgeu reuses the unsigned compare
                    3'b111: begin
                        dec.alu_op         = ALU_SLTU;
                        dec.branch_on_zero = 1'b1;
                    end
                    default: dec.is_branch = 1'b0;
                endcase
            end
            OP_LOAD: begin
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                // lw and lbu only
                if (funct3 == 3'b010 || funct3 == 3'b100) begin
                    dec.mem_ren   = 1'b1;
                    dec.reg_wen   = 1'b1;
                    dec.wb_sel    = WB_MEM;
                    dec.load_byte = (funct3 == 3'b100);
                end
            end
            OP_STORE: begin
                dec.imm         = imm_s;
                dec.src2_is_imm = 1'b1;
                // sb, sh, sw
                dec.mem_wen     = (funct3 == 3'b000) || (funct3 == 3'b001) ||
                                  (funct3 == 3'b010);
            end
            OP_IMM: begin
                dec.imm         = imm_i;
                dec.src2_is_imm = 1'b1;
                dec.reg_wen     = 1'b1;
                case (funct3)
                    3'b000: dec.alu_op = ALU_ADD;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b011: dec.alu_op = ALU_SLTU;
                    3'b001: begin
                        dec.alu_op  = ALU_SLL;
                        dec.reg_wen = (funct7 == 7'b0000000);
                    end
                    // srli / srai split on funct7
                    3'b101: begin
                        dec.alu_op  = funct7[5] ? ALU_SRA : ALU_SRL;
                        dec.reg_wen = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                    end
                    default: dec.reg_wen = 1'b0;
                endcase
            end
            OP_REG: begin
                dec.reg_wen = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_011: dec.alu_op = ALU_SLTU;
                    10'b0000000_100: dec.alu_op = ALU_XOR;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    10'b0000000_001: dec.alu_op = ALU_SLL;
                    10'b0000000_101: dec.alu_op = ALU_SRL;
                    default:         dec.reg_wen = 1'b0;
                endcase
            end
            OP_SYSTEM: begin
                // only ebreak, everything else falls through as a no-op
                dec.is_ebreak = (inst == `NPC_EBREAK_INST);
            end
            default: begin
                dec.imm = '0;
            end
        endcase
    end

endmodule

/* hdl/npc_consts.svh */
`ifndef NPC_CONSTS_SVH
`define NPC_CONSTS_SVH

// first fetch address after reset
// also the base of the unified memory
`define NPC_RESET_PC 32'h8000_0000

// unified memory depth in 32-bit words
// address = reset pc + 4 * word index
`define NPC_MEM_WORDS 1024

// ebreak encoding, matched as a whole word
`define NPC_EBREAK_INST 32'h0010_0073

`endif

/* hdl/npc_core.sv */
`timescale 1ns/1ps
`include "npc_consts.svh"

module npc_core import npc_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] fetch_addr,
    input  logic [31:0] fetch_data,
    output mem_req_t    dmem_req,
    input  logic [31:0] dmem_rdata,
    output logic        commit_valid,
    output commit_t     commit,
    output logic        halt
);

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] pc_plus4;
    logic        halt_q;
    logic        retire;
    decode_t     dec;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic        br_taken;
    logic [31:0] load_shift;
    logic [31:0] load_data;
    logic [31:0] wb_data;
    logic [3:0]  store_mask;

    // one instruction per cycle while running
    assign retire   = !reset && !halt_q;
    assign pc_plus4 = pc + 32'd4;

    assign fetch_addr = pc;

    inst_decoder u_dec (
        .inst (fetch_data),
        .dec  (dec)
    );

    register_file u_rf (
        .clk    (clk),
        .wen    (dec.reg_wen && retire),
        .waddr  (dec.rd),
        .wdata  (wb_data),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    // auipc takes pc, immediate forms take imm
    assign alu_a = dec.src1_is_pc ? pc : rs1_data;
    assign alu_b = dec.src2_is_imm ? dec.imm : rs2_data;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (dec.alu_op),
        .y  (alu_y)
    );

    // compare result 1 means taken, inverted for bge/bgeu
    assign br_taken = dec.is_branch && ((alu_y != 32'd0) ^ dec.branch_on_zero);

    always_comb begin
        if (dec.is_ebreak) begin
            // pc holds on ebreak
            next_pc = pc;
        end else if (dec.is_jalr) begin
            next_pc = alu_y & ~32'd1;
        end else if (dec.is_jal || br_taken) begin
            next_pc = pc + dec.imm;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // store width from funct3 low bits: byte, half, word
    always_comb begin
        case (fetch_data[13:12])
            2'b00:   store_mask = 4'b0001;
            2'b01:   store_mask = 4'b0011;
            default: store_mask = 4'b1111;
        endcase
    end

    // idle address on non-memory instructions keeps reads in range
    assign dmem_req.addr  = (dec.mem_ren || dec.mem_wen) ? alu_y : `NPC_RESET_PC;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.wmask = store_mask;
    assign dmem_req.wen   = dec.mem_wen && retire;

    // lbu picks the addressed byte, zero extended
    assign load_shift = dmem_rdata >> {dmem_req.addr[1:0], 3'b000};
    assign load_data  = dec.load_byte ? {24'd0, load_shift[7:0]} : dmem_rdata;

    always_comb begin
        case (dec.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_PC4:  wb_data = pc_plus4;
            WB_IMM:  wb_data = dec.imm;
            default: wb_data = alu_y;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc     <= `NPC_RESET_PC;
            halt_q <= 1'b0;
        end else if (retire) begin
            pc     <= next_pc;
            halt_q <= dec.is_ebreak;
        end
    end

    assign halt = halt_q;

    // commit reports what gets written at the next edge
    assign commit_valid = retire;
    assign commit.pc    = pc;
    assign commit.rd    = dec.rd;
    assign commit.wdata = wb_data;
    assign commit.wen   = dec.reg_wen && dec.rd != 5'd0;

    // jump and branch targets must stay word aligned for the fetch port
    a_next_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        retire |-> (next_pc[1:0] == 2'b00));

endmodule

/* hdl/npc_pkg.sv */
package npc_pkg;

    // alu operations
    // eq/ne/lt/sltu give 1 or 0, used by the branches
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_EQ,
        ALU_NE,
        ALU_LT
    } alu_op_t;

    // write-back source select
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4,
        WB_IMM
    } wb_sel_t;

    // everything the core needs from one instruction
    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        reg_wen;
        logic        mem_ren;
        logic        mem_wen;
        logic        load_byte;
        wb_sel_t     wb_sel;
        logic        is_branch;
        // branch taken when alu result is zero (bge, bgeu)
        logic        branch_on_zero;
        logic        is_jal;
        logic        is_jalr;
        logic        is_ebreak;
    } decode_t;

    // data side request, mask is unshifted (lane 0 based)
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        wen;
    } mem_req_t;

    // one retired instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        wen;
    } commit_t;

    // program-load word
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } prog_t;

endpackage

/* hdl/npc_top.sv */
`timescale 1ns/1ps

module npc_top import npc_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    prog_valid,
    input  prog_t   prog,
    output logic    commit_valid,
    output commit_t commit,
    output logic    halt
);

    logic [31:0] fetch_addr;
    logic [31:0] fetch_data;
    mem_req_t    dmem_req;
    logic [31:0] dmem_rdata;

    npc_core u_core (
        .clk          (clk),
        .reset        (reset),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .dmem_req     (dmem_req),
        .dmem_rdata   (dmem_rdata),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halt         (halt)
    );

    // instructions and data share one array
    unified_mem u_mem (
        .clk        (clk),
        .prog_valid (prog_valid),
        .prog       (prog),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        wen,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [0:31];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // async reads, x0 forced to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

/* hdl/unified_mem.sv */
`timescale 1ns/1ps
`include "npc_consts.svh"

module unified_mem import npc_pkg::*; (
    input  logic        clk,
    input  logic        prog_valid,
    input  prog_t       prog,
    input  logic [31:0] fetch_addr,
    output logic [31:0] fetch_data,
    input  mem_req_t    dmem_req,
    output logic [31:0] dmem_rdata
);

    localparam int IDX_W = $clog2(`NPC_MEM_WORDS);

    logic [31:0]      mem [0:`NPC_MEM_WORDS-1];
    logic [31:0]      fetch_off;
    logic [31:0]      data_off;
    logic [31:0]      prog_off;
    logic [3:0]       lane_mask;
    logic [31:0]      lane_data;
    logic [IDX_W-1:0] data_idx;

    // byte offsets from the memory base
    assign fetch_off = fetch_addr - `NPC_RESET_PC;
    assign data_off  = dmem_req.addr - `NPC_RESET_PC;
    assign prog_off  = prog.addr - `NPC_RESET_PC;
    assign data_idx  = data_off[IDX_W+1:2];

    // both read ports async, whole words
    assign fetch_data = mem[fetch_off[IDX_W+1:2]];
    assign dmem_rdata = mem[data_idx];

    // move sb/sh lanes up to the addressed byte
    assign lane_mask = dmem_req.wmask << dmem_req.addr[1:0];
    assign lane_data = dmem_req.wdata << {dmem_req.addr[1:0], 3'b000};

    always_ff @(posedge clk) begin
        // program load wins over a data store
        if (prog_valid) begin
            mem[prog_off[IDX_W+1:2]] <= prog.data;
        end else if (dmem_req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_mask[b]) begin
                    mem[data_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    // sw from the core must be aligned, no lane can drop off the top
    a_word_aligned: assert property (@(posedge clk)
        (dmem_req.wen && dmem_req.wmask == 4'hf) |-> (dmem_req.addr[1:0] == 2'b00));

endmodule

/* verif/npc_tb.sv */
`timescale 1ns/1ps
`include "npc_consts.svh"

module npc_tb import npc_pkg::*; ();

    localparam string TEST_FILE = "verif/npc_tests.txt";

    logic    clk;
    logic    reset;
    logic    prog_valid;
    prog_t   prog;
    logic    commit_valid;
    commit_t commit;
    logic    halt;

    // whole test file, flattened across tests
    logic [31:0] words [$];
    logic [31:0] exp_pc [$];
    int          exp_rd [$];
    logic [31:0] exp_val [$];
    int          word_cnt [$];
    int          write_cnt [$];
    logic [31:0] halt_pcs [$];

    int   errors;
    int   checks;
    int   watchdog_cycles;
    logic loaded;

    npc_top u_npc_top (
        .clk          (clk),
        .reset        (reset),
        .prog_valid   (prog_valid),
        .prog         (prog),
        .commit_valid (commit_valid),
        .commit       (commit),
        .halt         (halt)
    );

    always #5 clk = ~clk;

    // at least 10 reset cycles, longer programs keep reset up while loading
    function automatic int load_cycles(input int n);
        return (n > 10) ? n : 10;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Error: %s exp %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic read_tests(output bit ok);
        int               fd;
        int               n;
        int               code;
        int               rd;
        logic [31:0]      w;
        logic [31:0]      pc;
        logic [31:0]      val;
        logic [8*256-1:0] hdr;
        ok = 1'b0;
        fd = $fopen(TEST_FILE, "r");
        if (fd != 0) begin
            // two column-description lines at the top
            code = $fgets(hdr, fd);
            code = $fgets(hdr, fd);
            code = $fscanf(fd, "%d", n);
            // a word count of zero closes the list
            while (code == 1 && n > 0) begin
                word_cnt.push_back(n);
                repeat (n) begin
                    code = $fscanf(fd, "%h", w);
                    words.push_back(w);
                end
                code = $fscanf(fd, "%d", n);
                write_cnt.push_back(n);
                repeat (n) begin
                    code = $fscanf(fd, "%h %d %h", pc, rd, val);
                    exp_pc.push_back(pc);
                    exp_rd.push_back(rd);
                    exp_val.push_back(val);
                end
                code = $fscanf(fd, "%h", w);
                halt_pcs.push_back(w);
                code = $fscanf(fd, "%d", n);
            end
            $fclose(fd);
            ok = (word_cnt.size() > 0);
        end
    endtask

    task automatic run_test(input int t, input int wbase, input int ebase);
        int          e;
        int          cycles;
        logic [31:0] last_pc;
        bit          done;
        e       = ebase;
        last_pc = '0;
        done    = 1'b0;
        cycles  = load_cycles(word_cnt[t]);
        // program goes in one word per edge under reset
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            #1;
            reset      = 1'b1;
            prog_valid = (i < word_cnt[t]);
            prog.addr  = `NPC_RESET_PC + 32'(4 * i);
            prog.data  = (i < word_cnt[t]) ? words[wbase + i] : 32'd0;
        end
        @(posedge clk);
        #1;
        prog_valid = 1'b0;
        reset      = 1'b0;
        // commits sampled mid-cycle, one per cycle until halt
        while (!done) begin
            @(negedge clk);
            if (commit_valid) begin
                last_pc = commit.pc;
                if (commit.wen && e >= ebase + write_cnt[t]) begin
                    $display("test %0d wrote a register after the expected trace ended", t);
                    errors++;
                end else if (commit.wen) begin
                    compare("commit.pc", commit.pc, exp_pc[e]);
                    compare("commit.rd", 32'(commit.rd), exp_rd[e]);
                    compare("commit.wdata", commit.wdata, exp_val[e]);
                    e++;
                end
            end else if (halt) begin
                done = 1'b1;
            end
        end
        // last commit before halt is the ebreak itself
        compare("commit.pc", last_pc, halt_pcs[t]);
        if (e != ebase + write_cnt[t]) begin
            $display("test %0d halted with %0d expected writes never seen",
                     t, ebase + write_cnt[t] - e);
            errors++;
        end
        repeat (10) begin
            @(negedge clk);
            if (commit_valid) begin
                $display("test %0d retired an instruction after halt", t);
                errors++;
            end
            if (!halt) begin
                $display("test %0d dropped halt without a reset", t);
                errors++;
            end
        end
    endtask

    initial begin
        bit ok;
        int wbase;
        int ebase;
        clk        = 1'b0;
        reset      = 1'b1;
        prog_valid = 1'b0;
        prog       = '0;
        errors     = 0;
        checks     = 0;
        loaded     = 1'b0;
        wbase      = 0;
        ebase      = 0;
        read_tests(ok);
        if (!ok) begin
            $display("could not read any test from %s", TEST_FILE);
            errors++;
        end else begin
            // commits plus reset cycles, times 20
            watchdog_cycles = 0;
            foreach (word_cnt[t]) begin
                watchdog_cycles += write_cnt[t] + load_cycles(word_cnt[t]) + 1;
            end
            watchdog_cycles *= 20;
            loaded = 1'b1;
            foreach (word_cnt[t]) begin
                run_test(t, wbase, ebase);
                wbase += word_cnt[t];
                ebase += write_cnt[t];
            end
        end
        $display("tests %0d checks %0d errors %0d", word_cnt.size(), checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // hung core or missing halt
    initial begin
        wait (loaded);
        #(watchdog_cycles * 10);
        $display("watchdog expired after %0d cycles, the core never finished", watchdog_cycles);
        $display("tests %0d checks %0d errors %0d", word_cnt.size(), checks, errors + 1);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* verif/npc_tests.txt */
# per test: word count (dec), program words (hex), write count (dec)
# then per write: pc (hex) rd (dec) value (hex); then halt pc (hex); word count 0 ends
17
12300093 ffb00113 002081b3 40208233 0020b2b3 00713313 0020c3b3 0020e433
0020f4b3 0f017513 fff0c593 00409613 00415693 40415713 005097b3 00515833
00100073
16
80000000 1 00000123
80000004 2 fffffffb
80000008 3 0000011e
8000000c 4 00000128
80000010 5 00000001
80000014 6 00000000
80000018 7 fffffed8
8000001c 8 fffffffb
80000020 9 00000123
80000024 10 000000f0
80000028 11 fffffedc
8000002c 12 00001230
80000030 13 0fffffff
80000034 14 ffffffff
80000038 15 00000246
8000003c 16 7ffffffd
80000040
10
123450b7 00001117 00c001ef 00100213 00200213 015182e7 00300313 00400313
05500393 00100073
5
80000000 1 12345000
80000004 2 80001004
80000008 3 8000000c
80000014 5 80000018
80000020 7 00000055
80000024
29
00500093 ffd00113 00500193 00308463 00100513 00100593 00208463 00100613
00209463 00200513 00100693 00309463 00100713 0020d463 00300513 00100793
00115463 00100813 0020e463 00400513 00100893 00116463 00100913 00117463
00500513 00100993 0020f463 00100a13 00100073
13
80000000 1 00000005
80000004 2 fffffffd
80000008 3 00000005
80000014 11 00000001
8000001c 12 00000001
80000028 13 00000001
80000030 14 00000001
8000003c 15 00000001
80000044 16 00000001
80000050 17 00000001
80000058 18 00000001
80000064 19 00000001
8000006c 20 00000001
80000070
15
800000b7 20008093 11223137 34410113 0020a023 0ab00193 003080a3 ffe00213
00409123 0000a283 0010c303 0030c383 00500013 00300433 00100073
10
80000000 1 80000000
80000004 1 80000200
80000008 2 11223000
8000000c 2 11223344
80000014 3 000000ab
8000001c 4 fffffffe
80000024 5 fffeab44
80000028 6 000000ab
8000002c 7 000000ff
80000034 8 000000ab
80000038
0

/* verilog.f */
+incdir+hdl
hdl/npc_pkg.sv
hdl/inst_decoder.sv
hdl/alu.sv
hdl/register_file.sv
hdl/unified_mem.sv
hdl/npc_core.sv
hdl/npc_top.sv
verif/npc_tb.sv
